//--- compile.f
logic/ibuf_pkg.sv
logic/ibuf_fill_if.sv
logic/ibuf_entry_array.sv
logic/ibuf_fill_gen.sv
logic/ibuf_flow_fsm.sv
logic/ibuf_shift_encoder.sv
logic/ibuf_ctl.sv
tb/ibuf_ctl_assert.sv
tb/tb_ibuf_ctl.sv

//--- logic/ibuf_ctl.sv
//####################
// instruction buffer control top level
//####################

`timescale 1ns/100ps

module ibuf_ctl
    import ibuf_pkg::*;
#(
    parameter int DEPTH = IBUF_DEPTH
) (
    input  logic              clk,
    input  logic              reset_l,
    input  logic              icu_stall,
    input  logic              jmp_e,
    input  shift_sel_t        iu_shift_d,
    input  fetch_addr_t       icu_addr_2_0,
    input  logic              icu_bypass_q,    // uncached fetch path
    input  logic              ic_drty,
    output logic              ibuf_enable,
    output pc_sel_t           ibuf_pc_sel,
    output logic              ibuf_full,
    output logic [DEPTH-1:0]  ic_dout_sel,     // first fill byte position
    output logic [DEPTH-1:0]  valid,
    output logic [DEPTH-1:0]  dirty,
    output shift_cnt_t        encod_shift_e
);

    logic update_en;
    logic squash;

    ibuf_fill_if #(.DEPTH(DEPTH)) fill_bus ();

    ibuf_flow_fsm u_flow (
        .clk         (clk),
        .reset_l     (reset_l),
        .icu_stall   (icu_stall),
        .jmp_e       (jmp_e),
        .iu_shift_d  (iu_shift_d),
        .ibuf_enable (ibuf_enable),
        .update_en   (update_en),
        .squash      (squash),
        .ibuf_pc_sel (ibuf_pc_sel)
    );

    ibuf_entry_array #(.DEPTH(DEPTH)) u_entries (
        .clk       (clk),
        .reset_l   (reset_l),
        .update_en (update_en),
        .jmp_e     (jmp_e),
        .shift_sel (iu_shift_d),
        .fill      (fill_bus.array)
    );

    ibuf_fill_gen #(.DEPTH(DEPTH)) u_fill (
        .icu_stall    (icu_stall),
        .icu_bypass_q (icu_bypass_q),
        .ic_drty      (ic_drty),
        .squash       (squash),
        .icu_addr_2_0 (icu_addr_2_0),
        .ic_dout_sel  (ic_dout_sel),
        .ibuf_full    (ibuf_full),
        .fill         (fill_bus.fill)
    );

    ibuf_shift_encoder u_shift_enc (
        .clk           (clk),
        .reset_l       (reset_l),
        .iu_shift_d    (iu_shift_d),
        .encod_shift_e (encod_shift_e)
    );

    assign valid = fill_bus.valid;
    assign dirty = fill_bus.dirty;

endmodule

//--- logic/ibuf_entry_array.sv
//####################
// per-entry valid and dirty flags
// shift-and-fill next-state logic
//####################

`timescale 1ns/100ps

module ibuf_entry_array
    import ibuf_pkg::*;
#(
    parameter int DEPTH = IBUF_DEPTH
) (
    input  logic         clk,
    input  logic         reset_l,
    input  logic         update_en,
    input  logic         jmp_e,
    input  shift_sel_t   shift_sel,
    ibuf_fill_if.array   fill
);

    logic [DEPTH-1:0] merged_v;
    logic [DEPTH-1:0] merged_d;
    logic [DEPTH+SHIFT_W-1:0] ext_v;    // zero padded above the top entry
    logic [DEPTH+SHIFT_W-1:0] ext_d;

    // current flags plus whatever lands this cycle
    assign merged_v = fill.valid | fill.new_valid;
    assign merged_d = fill.dirty | fill.new_dirty;
    assign ext_v    = {{SHIFT_W{1'b0}}, merged_v};
    assign ext_d    = {{SHIFT_W{1'b0}}, merged_d};

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        logic v_sel;
        logic d_sel;
        logic v_q;
        logic d_q;

        // priority mux, the largest set shift bit wins
        always_comb begin
            v_sel = ext_v[i];
            d_sel = ext_d[i];
            for (int k = 1; k < SHIFT_W; k++) begin
                if (shift_sel[k]) begin
                    v_sel = ext_v[i+k];
                    d_sel = ext_d[i+k];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (!reset_l) begin
                v_q <= 1'b0;
                d_q <= 1'b0;
            end else if (update_en) begin
                v_q <= v_sel & ~jmp_e;  // taken jump empties the buffer
                d_q <= d_sel & ~jmp_e;
            end
        end

        assign fill.valid[i] = v_q;
        assign fill.dirty[i] = d_q;
    end

endmodule

//--- logic/ibuf_fill_gen.sv
//####################
// fill position, new valid/dirty masks
// and the buffer full flag
//####################

`timescale 1ns/100ps

module ibuf_fill_gen
    import ibuf_pkg::*;
#(
    parameter int DEPTH = IBUF_DEPTH
) (
    input  logic              icu_stall,
    input  logic              icu_bypass_q,
    input  logic              ic_drty,
    input  logic              squash,
    input  fetch_addr_t       icu_addr_2_0,
    output logic [DEPTH-1:0]  ic_dout_sel,
    output logic              ibuf_full,
    ibuf_fill_if.fill         fill
);

    logic [DEPTH-1:0] first_empty;
    logic [DEPTH-1:0] run;
    logic [3:0]       fill_cnt;     // 1..8 bytes

    // valid is a thermometer, so the edge marks the first empty slot
    always_comb begin
        first_empty[0] = ~fill.valid[0];
        for (int i = 1; i < DEPTH; i++) begin
            first_empty[i] = fill.valid[i-1] & ~fill.valid[i];
        end
    end

    assign fill_cnt = icu_bypass_q ? 4'(BYPASS_BYTES)
                                   : 4'(LINE_BYTES) - {1'b0, icu_addr_2_0};

    // run of fill_cnt ones from the fill position, top overflow is dropped
    always_comb begin
        run = '0;
        for (int p = 0; p < DEPTH; p++) begin
            for (int j = 0; j < LINE_BYTES; j++) begin
                if (first_empty[p] && (j < fill_cnt) && (p + j < DEPTH)) begin
                    run[p+j] = 1'b1;
                end
            end
        end
    end

    assign ic_dout_sel    = first_empty;
    assign fill.new_valid = icu_stall ? '0 : run;  // nothing lands during a stall
    assign fill.new_dirty = (!icu_stall && icu_bypass_q && ic_drty) ? run : '0;

    // bypass fills are smaller, so allow the buffer to run further up
    assign ibuf_full = (fill.valid[DEPTH-4] | (~icu_bypass_q & fill.valid[DEPTH/2]))
                       & ~squash;

endmodule

//--- logic/ibuf_fill_if.sv
//####################
// flag vectors and fill masks between
// the entry array and the fill generator
//####################

`timescale 1ns/100ps

interface ibuf_fill_if
    import ibuf_pkg::*;
#(
    parameter int DEPTH = IBUF_DEPTH
) ();

    logic [DEPTH-1:0] valid;        // current valid thermometer
    logic [DEPTH-1:0] dirty;        // current dirty flags
    logic [DEPTH-1:0] new_valid;    // entries written by this cycle's fill
    logic [DEPTH-1:0] new_dirty;    // fill entries that come in dirty

    modport array (output valid, output dirty, input new_valid, input new_dirty);

    modport fill (input valid, input dirty, output new_valid, output new_dirty);

endinterface

//--- logic/ibuf_flow_fsm.sv
//####################
// run/squash state, PC select
// and the buffer update enables
//####################

`timescale 1ns/100ps

module ibuf_flow_fsm
    import ibuf_pkg::*;
(
    input  logic        clk,
    input  logic        reset_l,
    input  logic        icu_stall,
    input  logic        jmp_e,
    input  shift_sel_t  iu_shift_d,
    output logic        ibuf_enable,
    output logic        update_en,
    output logic        squash,
    output pc_sel_t     ibuf_pc_sel
);

    flow_state_t state_q;
    flow_state_t state_d;

    // squash covers the refill from the branch target
    assign state_d = jmp_e ? SQUASH : RUN;  // a new jump keeps it in squash

    always_ff @(posedge clk) begin
        if (!reset_l) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign squash      = (state_q == SQUASH);
    assign ibuf_pc_sel = squash ? BRANCH_PC : SEQ_PC;

    // only a stall with no shift freezes the buffer
    assign ibuf_enable = ~icu_stall | ~iu_shift_d[0];
    assign update_en   = ibuf_enable | jmp_e;   // jump must clear even when frozen

endmodule

//--- logic/ibuf_pkg.sv
//####################
// buffer constants, shift select and count types,
// PC select encoding and flow state type
//####################

package ibuf_pkg;

    // buffer geometry
    localparam int IBUF_DEPTH   = 16;   // default entry count
    localparam int SHIFT_W      = 8;    // one-hot shift select width

    // fill sizes
    localparam int BYPASS_BYTES = 4;    // bytes per uncached fill
    localparam int LINE_BYTES   = 8;    // cache fill before address offset

    // bit k set means consume k bytes, bit 0 is no shift
    typedef logic [SHIFT_W-1:0] shift_sel_t;

    typedef logic [2:0] shift_cnt_t;    // encoded shift amount
    typedef logic [2:0] fetch_addr_t;   // low PC bits

    // one-hot select for the PC mux in the data path
    typedef enum logic [1:0] {
        SEQ_PC    = 2'b01,
        BRANCH_PC = 2'b10
    } pc_sel_t;

    typedef enum logic {
        RUN    = 1'b0,
        SQUASH = 1'b1   // first cycle after a taken jump
    } flow_state_t;

endpackage

//--- logic/ibuf_shift_encoder.sv
//####################
// shift select register and
// one-hot to count encoder
//####################

`timescale 1ns/100ps

module ibuf_shift_encoder
    import ibuf_pkg::*;
(
    input  logic        clk,
    input  logic        reset_l,
    input  shift_sel_t  iu_shift_d,
    output shift_cnt_t  encod_shift_e
);

    shift_sel_t shift_e;    // select from the previous cycle

    always_ff @(posedge clk) begin
        if (!reset_l) begin
            shift_e <= '0;
        end else begin
            shift_e <= iu_shift_d;
        end
    end

    // exact one-hot only, zero or multi-hot falls through to 0
    always_comb begin
        encod_shift_e = '0;
        for (int k = 1; k < SHIFT_W; k++) begin
            if (shift_e == (shift_sel_t'(1) << k)) encod_shift_e = shift_cnt_t'(k);
        end
    end

endmodule

//--- tb/ibuf_ctl_assert.sv
//####################
// concurrent checks on the buffer control top level
// PC select, valid shape, full/branch exclusion, jump clear
//####################

`timescale 1ns/100ps

module ibuf_ctl_assert
    import ibuf_pkg::*;
#(
    parameter int DEPTH = IBUF_DEPTH
) (
    input  logic              clk,
    input  logic              reset_l,
    input  logic              jmp_e,
    input  pc_sel_t           ibuf_pc_sel,
    input  logic              ibuf_full,
    input  logic [DEPTH-1:0]  valid
);

    // branch PC exactly in the cycle after a jump
    pc_sel_onehot: assert property (@(posedge clk) disable iff (!reset_l)
        $onehot(ibuf_pc_sel) && ((ibuf_pc_sel == BRANCH_PC) == $past(jmp_e)))
        else $error("ibuf_pc_sel is not one-hot or does not follow the jump");

    // no hole allowed below the highest valid entry
    valid_thermo: assert property (@(posedge clk) disable iff (!reset_l)
        (valid & (valid + 1'b1)) == '0)
        else $error("valid is not a thermometer from entry 0");

    full_not_branch: assert property (@(posedge clk) disable iff (!reset_l)
        !(ibuf_full && ibuf_pc_sel == BRANCH_PC))
        else $error("ibuf_full set while PC select is on the branch PC");

    jump_clears: assert property (@(posedge clk) disable iff (!reset_l)
        jmp_e |=> valid == '0)
        else $error("valid not cleared after a jump");

endmodule

bind ibuf_ctl ibuf_ctl_assert #(.DEPTH(DEPTH)) u_assert (
    .clk         (clk),
    .reset_l     (reset_l),
    .jmp_e       (jmp_e),
    .ibuf_pc_sel (ibuf_pc_sel),
    .ibuf_full   (ibuf_full),
    .valid       (valid)
);

//--- tb/tb_ibuf_ctl.sv
//####################
// testbench for the instruction buffer control
// stimulus table, random rows, reference model,
// compare tasks and watchdog
//####################

`timescale 1ns/100ps

module tb_ibuf_ctl
    import ibuf_pkg::*;
();

    localparam int DEPTH       = 16;
    localparam int TABLE_ROWS  = 24;
    localparam int RAND_ROWS   = 60;
    localparam int WATCHDOG_NS = (2 + TABLE_ROWS + RAND_ROWS + 10) * 100;

    typedef struct packed {
        shift_sel_t  shift;
        logic        stall;
        logic        jmp;
        logic        bypass;
        fetch_addr_t addr;
        logic        drty;
    } row_t;

    logic clk, reset_l, icu_stall, jmp_e, icu_bypass_q, ic_drty;
    shift_sel_t       iu_shift_d;
    fetch_addr_t      icu_addr_2_0;
    logic             ibuf_enable, ibuf_full;
    pc_sel_t          ibuf_pc_sel;
    logic [DEPTH-1:0] ic_dout_sel, valid, dirty;
    shift_cnt_t       encod_shift_e;

    row_t             rows [TABLE_ROWS];
    row_t             rnd_row;
    integer           seed, rnd;
    int               exp_n;            // model occupancy, valid is a thermometer
    logic [DEPTH-1:0] exp_dirty;
    logic             exp_squash;
    shift_sel_t       prev_shift;
    int               vec_errs, pc_errs, cnt_errs, bit_errs;

    ibuf_ctl #(.DEPTH(DEPTH)) dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_vec(input string what, input logic [DEPTH-1:0] got,
                             input logic [DEPTH-1:0] exp);
        if (got !== exp) begin
            vec_errs++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc_sel(input pc_sel_t got, input pc_sel_t exp);
        if (got !== exp) begin
            pc_errs++;
            $display("ERR %0t: ibuf_pc_sel is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_count(input shift_cnt_t got, input shift_cnt_t exp);
        if (got !== exp) begin
            cnt_errs++;
            $display("ERR %0t: encod_shift_e is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic [DEPTH-1:0] thermo(input int n);
        logic [DEPTH-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v[i] = 1'b1;
        return v;
    endfunction

    // highest set bit wins, bit 0 or nothing means no shift
    function automatic int shift_amount(input shift_sel_t s);
        int k;
        k = 0;
        for (int i = 1; i < SHIFT_W; i++) if (s[i]) k = i;
        return k;
    endfunction

    // a count only for a single set bit, zero or multi-hot gives 0
    function automatic shift_cnt_t onehot_count(input shift_sel_t s);
        if ($countones(s) != 1) begin
            return '0;
        end
        return shift_cnt_t'(shift_amount(s));
    endfunction

    // entry index just past the fill, capped at the top of the buffer
    function automatic int fill_top(input row_t r);
        int cnt;
        cnt = r.bypass ? BYPASS_BYTES : LINE_BYTES - int'(r.addr);
        if (r.stall) cnt = 0;
        return (exp_n + cnt > DEPTH) ? DEPTH : exp_n + cnt;
    endfunction

    task automatic check_outputs(input row_t r);
        logic [DEPTH-1:0] pos;
        logic full;
        pos  = (exp_n < DEPTH) ? ({{(DEPTH-1){1'b0}}, 1'b1} << exp_n) : '0;
        full = ((exp_n > DEPTH-4) || (!r.bypass && exp_n > DEPTH/2)) && !exp_squash;
        check_vec("valid", valid, thermo(exp_n));
        check_vec("dirty", dirty, exp_dirty);
        check_vec("ic_dout_sel", ic_dout_sel, pos);
        check_bit("ibuf_full", ibuf_full, full);
        check_bit("ibuf_enable", ibuf_enable, !r.stall || !r.shift[0]);
        check_pc_sel(ibuf_pc_sel, exp_squash ? BRANCH_PC : SEQ_PC);
        check_count(encod_shift_e, onehot_count(prev_shift));
    endtask

    task automatic update_model(input row_t r);
        int top;
        int k;
        logic [DEPTH-1:0] merged_d;
        top      = fill_top(r);
        k        = shift_amount(r.shift);
        merged_d = exp_dirty;
        if (!r.stall && r.bypass && r.drty) begin
            for (int i = exp_n; i < top; i++) merged_d[i] = 1'b1;
        end
        if (r.jmp) begin
            exp_n     = 0;
            exp_dirty = '0;
        end else if (!r.stall || !r.shift[0]) begin
            exp_dirty = merged_d >> k;
            exp_n     = (top > k) ? top - k : 0;
        end
        exp_squash = r.jmp;
        prev_shift = r.shift;
    endtask

    task automatic run_row(input row_t r);
        iu_shift_d   = r.shift;
        icu_stall    = r.stall;
        jmp_e        = r.jmp;
        icu_bypass_q = r.bypass;
        icu_addr_2_0 = r.addr;
        ic_drty      = r.drty;
        #40;                            // outputs settled at the falling edge
        check_outputs(r);
        update_model(r);
        @(posedge clk);
        #10;
    endtask

    // shift, stall, jump, bypass, address, dirty-in
    task automatic load_table();
        rows[0]  = {8'h01, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0};  // idle after reset
        rows[1]  = {8'h01, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0};
        rows[2]  = {8'h01, 1'b0, 1'b0, 1'b1, 3'd0, 1'b1};  // dirty bypass fill
        rows[3]  = {8'h01, 1'b1, 1'b0, 1'b1, 3'd0, 1'b1};  // frozen
        rows[4]  = {8'h01, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0};
        rows[5]  = {8'h01, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0};
        rows[6]  = {8'h01, 1'b1, 1'b0, 1'b1, 3'd0, 1'b0};  // bypass threshold
        rows[7]  = {8'h80, 1'b1, 1'b0, 1'b1, 3'd0, 1'b0};  // stalled shift
        rows[8]  = {8'h01, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0};  // cache threshold
        rows[9]  = {8'h04, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0};
        rows[10] = {8'h01, 1'b0, 1'b1, 1'b0, 3'd0, 1'b0};
        rows[11] = {8'h01, 1'b0, 1'b0, 1'b0, 3'd3, 1'b1};  // cache fill stays clean
        rows[12] = {8'h01, 1'b0, 1'b1, 1'b1, 3'd0, 1'b1};
        rows[13] = {8'h01, 1'b0, 1'b1, 1'b1, 3'd0, 1'b1};  // back-to-back jump
        rows[14] = {8'h01, 1'b0, 1'b0, 1'b1, 3'd0, 1'b1};
        rows[15] = {8'h02, 1'b0, 1'b0, 1'b0, 3'd5, 1'b0};
        rows[16] = {8'h08, 1'b0, 1'b0, 1'b0, 3'd7, 1'b0};
        rows[17] = {8'h10, 1'b0, 1'b0, 1'b1, 3'd0, 1'b1};
        rows[18] = {8'h20, 1'b0, 1'b0, 1'b0, 3'd2, 1'b0};
        rows[19] = {8'h40, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0};
        rows[20] = {8'h80, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0};
        rows[21] = {8'h02, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0};
        rows[22] = {8'h01, 1'b0, 1'b0, 1'b0, 3'd1, 1'b0};
        rows[23] = {8'h01, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0};
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run hung before all rows were applied");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset_l = 1'b0;
        icu_stall = 1'b1;
        jmp_e = 1'b0;
        icu_bypass_q = 1'b0;
        ic_drty = 1'b0;
        iu_shift_d = 8'h01;
        icu_addr_2_0 = '0;
        seed = 95970;
        exp_n = 0;
        exp_dirty = '0;
        exp_squash = 1'b0;
        prev_shift = '0;
        vec_errs = 0;
        pc_errs = 0;
        cnt_errs = 0;
        bit_errs = 0;
        load_table();
        repeat (2) @(posedge clk);
        #10 reset_l = 1'b1;
        for (int i = 0; i < TABLE_ROWS; i++) run_row(rows[i]);
        for (int i = 0; i < RAND_ROWS; i++) begin
            rnd = $random(seed);
            rnd_row.shift  = shift_sel_t'(1) << rnd[2:0];
            rnd_row.stall  = rnd[3] & rnd[4];
            rnd_row.jmp    = (rnd[7:5] == 3'd0);   // about one jump in eight
            rnd_row.bypass = rnd[8];
            rnd_row.addr   = rnd[11:9];
            rnd_row.drty   = rnd[12];
            run_row(rnd_row);
        end
        $display("errors: vector %0d, pc_sel %0d, shift count %0d, single bit %0d",
                 vec_errs, pc_errs, cnt_errs, bit_errs);
        if (vec_errs + pc_errs + cnt_errs + bit_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
